// File: src.f
common/gain_pkg.sv
logic/apb_gain_regs.sv
amp_spi/amp_spi_master.sv
preamp/preamp_rx.sv
logic/gain_ctrl_top.sv
dv/gain_ctrl_tb.sv

// File: Bender.yml
package:
  name: gain_ctrl

sources:
  # Shared package first
  - common/gain_pkg.sv
  # Design
  - logic/apb_gain_regs.sv
  - amp_spi/amp_spi_master.sv
  - preamp/preamp_rx.sv
  - logic/gain_ctrl_top.sv
  # Testbench
  - target: test
    files:
      - dv/gain_ctrl_tb.sv

// File: dv/gain_ctrl_tb.sv
`timescale 1ns/1ps

module gain_ctrl_tb import gain_pkg::*; ();

	// Status polls allowed per frame or init
	localparam int POLL_LIMIT = 100;

	logic AMP_CS;
	logic reseted;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	gain_code_t gain_a;
	gain_code_t gain_b;

	// Expected outcome of one frame
	typedef struct packed {
		amp_conf_t applied;
		amp_conf_t readback;
		logic err_code;
	} frame_exp_t;

	// Observed outcome of one frame
	typedef struct packed {
		amp_conf_t applied;
		amp_conf_t readback;
		logic err_code;
		logic err_len;
		logic err_no_init;
		logic ready;
		gain_code_t gain_a;
		gain_code_t gain_b;
	} frame_obs_t;

	frame_exp_t exp_q[$];
	frame_obs_t obs_q[$];
	// Setting the amplifier holds in its shift register
	amp_conf_t model_conf;
	int unsigned seed_dummy;

	gain_ctrl_top DUT (
		.AMP_CS (AMP_CS),
		.reseted (reseted),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.gain_a (gain_a),
		.gain_b (gain_b)
	);

	initial begin
		AMP_CS = 1'b0;
		forever begin
			#5 AMP_CS = ~AMP_CS;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Reference model and compare
	////////////////////////////////////////////////////////////////////

	// Amplifier returns what it held and applies the new byte
	function automatic frame_exp_t ref_gain(input amp_conf_t prev, input amp_conf_t setting);
		frame_exp_t e;
		e.applied = setting;
		e.readback = prev;
		// Legal codes run from 1 to 7
		e.err_code = !(setting[7:4] >= 4'd1 && setting[7:4] <= 4'd7) ||
			!(setting[3:0] >= 4'd1 && setting[3:0] <= 4'd7);
		return e;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Pairs each observed frame with its expected outcome
	always @(negedge AMP_CS) begin
		frame_exp_t e;
		frame_obs_t o;
		if (exp_q.size() > 0 && obs_q.size() > 0) begin
			e = exp_q.pop_front();
			o = obs_q.pop_front();
			check_eq(o.applied, e.applied, "applied setting");
			check_eq(o.readback, e.readback, "readback");
			check_eq(o.err_code, e.err_code, "err_code");
			// Master frames always carry 8 bits
			check_eq(o.err_len, 1'b0, "err_len");
			check_eq(o.err_no_init, 1'b0, "err_no_init");
			check_eq(o.ready, 1'b1, "ready");
			check_eq(o.gain_a, e.applied[7:4], "gain_a");
			check_eq(o.gain_b, e.applied[3:0], "gain_b");
		end
	end

	////////////////////////////////////////////////////////////////////
	// APB requester
	////////////////////////////////////////////////////////////////////

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge AMP_CS);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge AMP_CS);
		#1;
		penable = 1'b1;
		// Response sampled mid access phase
		@(negedge AMP_CS);
		err = pslverr;
		// No wait states on this slave
		check_eq(pready, 1'b1, "pready on write");
		@(posedge AMP_CS);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge AMP_CS);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge AMP_CS);
		#1;
		penable = 1'b1;
		@(negedge AMP_CS);
		data = prdata;
		err = pslverr;
		check_eq(pready, 1'b1, "pready on read");
		@(posedge AMP_CS);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Poll STATUS until the master is idle
	task automatic wait_idle(output apb_data_t stat);
		int polls;
		logic err;
		polls = 0;
		apb_read(ADDR_STATUS, stat, err);
		while (stat[0]) begin
			if (polls >= POLL_LIMIT) begin
				$display("Timeout: master still busy after %0d status polls", POLL_LIMIT);
				$display("SIMULATION FAILED");
				$fatal(1, "busy timeout");
			end
			polls++;
			apb_read(ADDR_STATUS, stat, err);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Sequences
	////////////////////////////////////////////////////////////////////

	// Waits for the frame in flight and queues both outcomes
	task automatic collect_frame(input amp_conf_t setting);
		apb_data_t stat;
		apb_data_t rb;
		logic err;
		frame_obs_t obs;
		wait_idle(stat);
		apb_read(ADDR_READBACK, rb, err);
		obs.applied = stat[15:8];
		obs.readback = rb[7:0];
		obs.err_code = stat[3];
		obs.err_len = stat[2];
		obs.err_no_init = stat[4];
		obs.ready = stat[1];
		obs.gain_a = gain_a;
		obs.gain_b = gain_b;
		exp_q.push_back(ref_gain(model_conf, setting));
		obs_q.push_back(obs);
		model_conf = setting;
	endtask

	task automatic send_frame(input amp_conf_t setting);
		logic err;
		apb_write(ADDR_GAIN, {24'h0, setting}, err);
		check_eq(err, 1'b0, "pslverr on GAIN write");
		collect_frame(setting);
	endtask

	task automatic init_amp();
		apb_data_t stat;
		logic err;
		apb_write(ADDR_CTRL, 32'h1, err);
		check_eq(err, 1'b0, "pslverr on CTRL write");
		wait_idle(stat);
		check_eq(stat[1], 1'b1, "ready after init");
		check_eq(stat[15:8], 8'h0, "applied after init");
		// Shutdown clears the device register
		model_conf = '0;
	endtask

	function automatic gain_code_t rand_legal_code();
		return gain_code_t'(1 + ($urandom % 7));
	endfunction

	// Zero or 8 to 15
	function automatic gain_code_t rand_bad_code();
		int unsigned pick;
		pick = $urandom % 9;
		if (pick == 0) begin
			return 4'd0;
		end
		return gain_code_t'(7 + pick);
	endfunction

	initial begin
		apb_data_t stat;
		apb_data_t rd;
		logic err;
		amp_conf_t first;
		amp_conf_t second;
		int polls;
		seed_dummy = $urandom(32'hab474660);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_conf = '0;
		reseted = 1'b1;
		repeat (3) @(posedge AMP_CS);
		#1;
		reseted = 1'b0;

		// Frame sent to an uninitialized amplifier
		apb_write(ADDR_GAIN, 32'h35, err);
		check_eq(err, 1'b0, "pslverr on first GAIN write");
		wait_idle(stat);
		check_eq(stat[4], 1'b1, "err_no_init before init");
		check_eq(stat[1], 1'b0, "ready before init");
		check_eq(stat[2], 1'b0, "err_len before init");
		check_eq(stat[15:8], 8'h0, "applied before init");
		check_eq(gain_a, 4'h0, "gain_a before init");
		check_eq(gain_b, 4'h0, "gain_b before init");

		// Init, then a legal setting that reads back zero
		init_amp();
		send_frame(8'h52);

		repeat (20) begin
			send_frame({rand_legal_code(), rand_legal_code()});
		end

		// Bad nibble on each channel, then a legal one clears err_code
		send_frame({rand_bad_code(), rand_legal_code()});
		send_frame({rand_legal_code(), rand_bad_code()});
		send_frame({rand_legal_code(), rand_legal_code()});

		// Unknown addresses
		apb_write(4'h2, 32'h0, err);
		check_eq(err, 1'b1, "pslverr on unknown write");
		apb_read(4'h6, rd, err);
		check_eq(err, 1'b1, "pslverr on unknown read");

		// Second GAIN write lands while the first frame runs
		first = {rand_legal_code(), rand_legal_code()};
		second = (first == 8'h11) ? 8'h22 : 8'h11;
		apb_write(ADDR_GAIN, {24'h0, first}, err);
		check_eq(err, 1'b0, "pslverr on GAIN write");
		apb_write(ADDR_GAIN, {24'h0, second}, err);
		check_eq(err, 1'b1, "pslverr on GAIN write while busy");
		collect_frame(first);

		// Re-init clears the applied setting
		init_amp();
		send_frame({rand_legal_code(), rand_legal_code()});

		// Let the compare process drain its queues
		polls = 0;
		while ((exp_q.size() > 0 || obs_q.size() > 0) && polls < 10) begin
			@(posedge AMP_CS);
			polls++;
		end
		if (exp_q.size() == 0 && obs_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Frames were left unchecked at the end of the run");
			$display("SIMULATION FAILED");
			$fatal(1, "unchecked frames");
		end
	end

endmodule

// File: logic/gain_ctrl_top.sv
`timescale 1ns/1ps

module gain_ctrl_top import gain_pkg::*; (
	input logic AMP_CS,
	input logic reseted,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_addr_t paddr,
	input apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output gain_code_t gain_a,
	output gain_code_t gain_b
);

	// Register block to master
	logic start_frame;
	logic start_shdn;
	amp_conf_t conf;

	// Master to register block
	logic busy;
	logic done;
	amp_conf_t returned;

	// Serial link to the on-board amplifier model
	amp_bus_t amp_bus;
	logic dout;
	amp_status_t status;

	apb_gain_regs u_regs (
		.AMP_CS (AMP_CS),
		.reseted (reseted),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.busy (busy),
		.done (done),
		.returned (returned),
		.status (status),
		.start_frame (start_frame),
		.start_shdn (start_shdn),
		.conf (conf)
	);

	amp_spi_master u_master (
		.AMP_CS (AMP_CS),
		.reseted (reseted),
		.start_frame (start_frame),
		.start_shdn (start_shdn),
		.conf (conf),
		.dout (dout),
		.amp_bus (amp_bus),
		.busy (busy),
		.done (done),
		.returned (returned)
	);

	preamp_rx u_preamp (
		.AMP_CS (AMP_CS),
		.reseted (reseted),
		.amp_bus (amp_bus),
		.dout (dout),
		.status (status)
	);

	// Gains in force on each channel
	assign gain_a = status.applied[7:4];
	assign gain_b = status.applied[3:0];

endmodule

// File: preamp/preamp_rx.sv
`timescale 1ns/1ps

module preamp_rx import gain_pkg::*; (
	input logic AMP_CS,
	input logic reseted,
	input amp_bus_t amp_bus,
	output logic dout,
	output amp_status_t status
);

	// Previous line values for edge detection
	logic sck_q;
	logic cs_q;
	logic shdn_q;

	logic sck_rise;
	logic cs_fall;
	logic cs_rise;
	logic shdn_rise;
	logic shdn_fall;

	// Device shift register
	amp_conf_t conf;
	// Bits received in this frame, saturates
	logic [3:0] bit_cnt;

	// Frame checks
	logic len_ok;
	logic code_ok;

	// Legal codes are 1 to 7
	function automatic logic gain_legal(input gain_code_t code);
		return (code >= GAIN_MIN) && (code <= GAIN_MAX);
	endfunction

	////////////////////////////////////////////////////////////////////
	// Edge detection
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			sck_q <= 1'b0;
			cs_q <= 1'b1;
			shdn_q <= 1'b0;
		end else begin
			sck_q <= amp_bus.sck;
			cs_q <= amp_bus.cs;
			shdn_q <= amp_bus.shdn;
		end
	end

	assign sck_rise = amp_bus.sck & ~sck_q;
	assign cs_fall = ~amp_bus.cs & cs_q;
	assign cs_rise = amp_bus.cs & ~cs_q;
	assign shdn_rise = amp_bus.shdn & ~shdn_q;
	assign shdn_fall = ~amp_bus.shdn & shdn_q;

	assign len_ok = (bit_cnt == FRAME_BITS);
	assign code_ok = gain_legal(conf[7:4]) && gain_legal(conf[3:0]);

	// Oldest bit goes back out while selected
	assign dout = amp_bus.cs ? 1'b0 : conf[7];

	////////////////////////////////////////////////////////////////////
	// Shift register and bit count
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			conf <= '0;
			bit_cnt <= '0;
		end else if (shdn_rise) begin
			// Shutdown clears the device register
			conf <= '0;
			bit_cnt <= '0;
		end else if (cs_fall) begin
			bit_cnt <= '0;
		end else if (sck_rise) begin
			if (!amp_bus.cs) begin
				conf <= {conf[6:0], amp_bus.mosi};
				if (bit_cnt != 4'hf) begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				bit_cnt <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Status at the end of a frame
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			status <= '0;
		end else if (shdn_rise) begin
			status.applied <= '0;
		end else begin
			// Init completes when shutdown drops
			if (shdn_fall) begin
				status.ready <= 1'b1;
			end
			if (cs_rise) begin
				if (!status.ready) begin
					// Frame ignored by an uninitialized device
					status.err_no_init <= 1'b1;
				end else begin
					status.err_no_init <= 1'b0;
					status.err_len <= ~len_ok;
					// Codes only mean something in a full frame
					status.err_code <= len_ok & ~code_ok;
					// Bad codes still take effect
					if (len_ok) begin
						status.applied <= conf;
					end
				end
			end
		end
	end

	// Master frames never carry more than one byte
	a_frame_len: assert property (@(posedge AMP_CS) disable iff (reseted)
		!amp_bus.cs |-> (bit_cnt <= FRAME_BITS));

endmodule

// File: amp_spi/amp_spi_master.sv
`timescale 1ns/1ps

module amp_spi_master import gain_pkg::*; (
	input logic AMP_CS,
	input logic reseted,
	input logic start_frame,
	input logic start_shdn,
	input amp_conf_t conf,
	input logic dout,
	output amp_bus_t amp_bus,
	output logic busy,
	output logic done,
	output amp_conf_t returned
);

	master_state_t state;
	// Cycles spent in the current phase
	logic [3:0] tick_cnt;
	// Index of the bit on the line
	logic [3:0] bit_cnt;
	// Outgoing setting, MSB on the line
	amp_conf_t tx_shift;

	// Phase end markers
	logic lo_end;
	logic hi_end;
	logic last_bit;
	logic frame_go;
	logic shdn_go;

	assign lo_end = (state == SCK_LO) && (tick_cnt == SCK_HALF - 1);
	assign hi_end = (state == SCK_HI) && (tick_cnt == SCK_HALF - 1);
	assign last_bit = (bit_cnt == FRAME_BITS - 1);

	// Init has priority over a frame request
	assign shdn_go = (state == IDLE) && start_shdn;
	assign frame_go = (state == IDLE) && start_frame && !start_shdn;

	////////////////////////////////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			state <= IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			amp_bus <= '{sck: 1'b0, mosi: 1'b0, cs: 1'b1, shdn: 1'b0};
		end else begin
			done <= 1'b0;
			tick_cnt <= tick_cnt + 4'd1;
			case (state)
				IDLE: begin
					tick_cnt <= '0;
					bit_cnt <= '0;
					if (shdn_go) begin
						// Shutdown pulse resets the amplifier
						amp_bus.shdn <= 1'b1;
						busy <= 1'b1;
						state <= SHDN_HI;
					end else if (frame_go) begin
						busy <= 1'b1;
						state <= CS_SETUP;
					end
				end
				SHDN_HI: begin
					if (tick_cnt == SHDN_CYCLES - 1) begin
						amp_bus.shdn <= 1'b0;
						tick_cnt <= '0;
						state <= SHDN_LO;
					end
				end
				SHDN_LO: begin
					// Quiet gap after the shutdown pulse
					if (tick_cnt == CS_GUARD - 1) begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= IDLE;
					end
				end
				CS_SETUP: begin
					// Guard with CS high, then open the frame with the MSB
					if (tick_cnt == CS_GUARD - 1) begin
						amp_bus.cs <= 1'b0;
						amp_bus.mosi <= tx_shift[7];
						tick_cnt <= '0;
						state <= SCK_LO;
					end
				end
				SCK_LO: begin
					if (lo_end) begin
						amp_bus.sck <= 1'b1;
						tick_cnt <= '0;
						state <= SCK_HI;
					end
				end
				SCK_HI: begin
					if (hi_end) begin
						amp_bus.sck <= 1'b0;
						tick_cnt <= '0;
						if (last_bit) begin
							state <= CS_HOLD;
						end else begin
							// Next bit goes out with the falling edge
							bit_cnt <= bit_cnt + 4'd1;
							amp_bus.mosi <= tx_shift[6];
							state <= SCK_LO;
						end
					end
				end
				CS_HOLD: begin
					// CS low guard, CS rise, then CS high guard
					if (tick_cnt == CS_GUARD - 1) begin
						amp_bus.cs <= 1'b1;
					end
					if (tick_cnt == 2 * CS_GUARD - 1) begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// Data shift registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		// Outgoing data, moves one place per bit
		if (frame_go) begin
			tx_shift <= conf;
		end else if (hi_end) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
		// Device register is cleared by init
		if (shdn_go) begin
			returned <= '0;
		end else if (lo_end) begin
			// dout sampled on the last low cycle
			returned <= {returned[6:0], dout};
		end
	end

	// CS stays high outside of a sequence
	a_cs_idle: assert property (@(posedge AMP_CS) disable iff (reseted)
		!busy |-> amp_bus.cs);

	// No serial clock without chip select
	a_sck_cs: assert property (@(posedge AMP_CS) disable iff (reseted)
		amp_bus.cs |-> !amp_bus.sck);

endmodule

// File: logic/apb_gain_regs.sv
`timescale 1ns/1ps

module apb_gain_regs import gain_pkg::*; (
	input logic AMP_CS,
	input logic reseted,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_addr_t paddr,
	input apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic done,
	input amp_conf_t returned,
	input amp_status_t status,
	output logic start_frame,
	output logic start_shdn,
	output amp_conf_t conf
);

	// Access phase of an APB transfer
	logic access;
	// Address hits one of the four registers
	logic addr_ok;
	// Master busy or about to become busy
	logic locked;
	// Write to a register that starts a sequence
	logic wr_start_reg;
	// Accepted write
	logic wr_en;
	// Setting shifted back by the amplifier on the last frame
	amp_conf_t readback;

	////////////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////////////

	assign access = psel & penable;

	always_comb begin
		addr_ok = paddr inside {ADDR_CTRL, ADDR_GAIN, ADDR_STATUS, ADDR_READBACK};
	end

	// Start pulses are still in flight one cycle before busy rises
	assign locked = busy | start_frame | start_shdn;
	assign wr_start_reg = (paddr == ADDR_CTRL) | (paddr == ADDR_GAIN);

	// No wait states
	assign pready = 1'b1;

	// Unknown address, or a start register written while the master works
	assign pslverr = access & (~addr_ok | (pwrite & locked & wr_start_reg));

	// Rejected writes are dropped here
	assign wr_en = access & pwrite & ~pslverr;

	////////////////////////////////////////////////////////////////////
	// Registers and start pulses
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			start_frame <= 1'b0;
			start_shdn <= 1'b0;
			conf <= '0;
			readback <= '0;
		end else begin
			// Single-cycle pulses
			start_frame <= wr_en & (paddr == ADDR_GAIN);
			start_shdn <= wr_en & (paddr == ADDR_CTRL) & pwdata[0];
			// Gain byte kept for readout and for the master
			if (wr_en && paddr == ADDR_GAIN) begin
				conf <= amp_conf_t'(pwdata[7:0]);
			end
			// Previous setting returned by the amplifier
			if (done) begin
				readback <= returned;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				ADDR_GAIN: begin
					prdata[7:0] = conf;
				end
				ADDR_STATUS: begin
					prdata[0] = busy;
					prdata[1] = status.ready;
					prdata[2] = status.err_len;
					prdata[3] = status.err_code;
					prdata[4] = status.err_no_init;
					prdata[15:8] = status.applied;
				end
				ADDR_READBACK: begin
					prdata[7:0] = readback;
				end
				// CTRL is write only and reads as zero
				default: begin
					prdata = '0;
				end
			endcase
		end
	end

	// The master never sees a new start while it is still sequencing
	a_no_start_busy: assert property (@(posedge AMP_CS) disable iff (reseted)
		(start_frame || start_shdn) |-> !busy);

endmodule

// File: common/gain_pkg.sv
package gain_pkg;

	////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////

	// Gain code of one amplifier channel
	typedef logic [3:0] gain_code_t;

	// Full amplifier setting with channel A in the upper nibble
	typedef logic [7:0] amp_conf_t;

	// APB address and data words
	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register offsets
	localparam apb_addr_t ADDR_CTRL = 4'h0;
	localparam apb_addr_t ADDR_GAIN = 4'h4;
	localparam apb_addr_t ADDR_STATUS = 4'h8;
	localparam apb_addr_t ADDR_READBACK = 4'hC;

	////////////////////////////////////////////////////////////////////
	// Serial timing in AMP_CS cycles
	////////////////////////////////////////////////////////////////////

	localparam int SCK_HALF = 4;
	localparam int SHDN_CYCLES = 8;
	// Chip select guard before and after a frame
	localparam int CS_GUARD = 2;
	localparam int FRAME_BITS = 8;

	// Legal gain code range
	localparam gain_code_t GAIN_MIN = 4'd1;
	localparam gain_code_t GAIN_MAX = 4'd7;

	// Master sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SHDN_HI,
		SHDN_LO,
		CS_SETUP,
		SCK_LO,
		SCK_HI,
		CS_HOLD
	} master_state_t;

	// Receiver status as seen by the register block
	typedef struct packed {
		logic ready;
		logic err_len;
		logic err_code;
		logic err_no_init;
		amp_conf_t applied;
	} amp_status_t;

	// Serial lines from master to amplifier
	typedef struct packed {
		logic sck;
		logic mosi;
		logic cs;
		logic shdn;
	} amp_bus_t;

endpackage
